//--- common/adc_pkg.sv
// Shared types and constants for the motor feedback ADC subsystem.
// Covers sample and register word types, LTC1864 frame timing and
// the register map used by the read mux and the config block.
// Import with a wildcard inside the module body; use scoped names in port lists.

`default_nettype none

package adc_pkg;

    // data types
    typedef logic [15:0] adc_sample_t;   // one LTC1864 code
    typedef logic [15:0] reg_addr_t;     // register address
    typedef logic [31:0] reg_data_t;     // register word

    // frame timing, in clkadc cycles
    localparam int CONV_CYCLES  = 8;     // conv high time
    localparam int SHIFT_BITS   = 16;    // bits per frame
    localparam int FRAME_CYCLES = CONV_CYCLES + 2 * SHIFT_BITS;   // sclk at clkadc/2

    // sequencer counter, must hold SHIFT_BITS and CONV_CYCLES-1
    localparam int SEQ_CNT_W = 5;

    // address decode
    localparam int ADDR_CFG_BIT = 8;     // set -> config space
    localparam int CHAN_LSB     = 4;     // channel field low bit
    localparam int CHAN_W       = 4;     // channel field width
    localparam int CFG_OFS_W    = 4;     // config offset field, bits 3:0

    // config space offsets
    localparam logic [CFG_OFS_W-1:0] CFG_CTRL_ADDR   = 4'd0;  // bit 0 enable
    localparam logic [CFG_OFS_W-1:0] CFG_PERIOD_ADDR = 4'd1;  // sample period
    localparam logic [CFG_OFS_W-1:0] CFG_COUNT_ADDR  = 4'd2;  // frame counter, read only

    // shortest period that still fits a whole frame plus a gap
    localparam int PERIOD_MIN = FRAME_CYCLES + 2;

    // quad reader sequencer
    typedef enum logic [1:0] {
        IDLE,       // waiting for start
        CONVERT,    // conv high
        SHIFT       // clocking bits out of the parts
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/ltc1864_quad/ltc1864_quad.sv
// Reader for four LTC1864 ADCs that share one conv and one sclk line.
// A start tick runs one frame: conv high for CONV_CYCLES, then SHIFT_BITS
// sclk periods at clkadc/2 with miso taken on each sclk rise, MSB first.
// The four codes are held on out1..out4 and done pulses once per frame.
// A start seen while a frame is running is dropped.

`timescale 1ns/100ps
`default_nettype none

module ltc1864_quad (
    input  wire                  clkadc,
    input  wire                  rst,
    input  wire                  start,     // one-cycle frame request
    input  wire [1:4]            miso,      // one data line per part
    output logic                 sclk,      // shared serial clock
    output logic                 conv,      // shared convert strobe
    output adc_pkg::adc_sample_t out1,
    output adc_pkg::adc_sample_t out2,
    output adc_pkg::adc_sample_t out3,
    output adc_pkg::adc_sample_t out4,
    output logic                 done       // new codes on out1..out4
);

    import adc_pkg::*;

    seq_state_t           state;
    logic [SEQ_CNT_W-1:0] cnt;              // conv cycles, then sclk rises
    adc_sample_t          shreg [1:4];      // per-part shift registers
    logic                 sclk_rise;        // sclk goes high at this edge
    logic                 last_bit;         // all bits in, close the frame

    // sclk low this cycle means it rises at the coming edge
    assign sclk_rise = (state == SHIFT) && !sclk;

    // last rise already happened, we sit in the final high phase
    assign last_bit = (state == SHIFT) && sclk
                   && (cnt == SEQ_CNT_W'(SHIFT_BITS));

    // frame sequencer
    always_ff @(posedge clkadc) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
            conv  <= 1'b0;
            sclk  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;                       // strobe by default
            case (state)
                IDLE: begin
                    sclk <= 1'b0;
                    if (start) begin
                        state <= CONVERT;
                        conv  <= 1'b1;          // conv rises the cycle after start
                        cnt   <= '0;
                    end
                end
                CONVERT: begin
                    if (cnt == SEQ_CNT_W'(CONV_CYCLES - 1)) begin
                        state <= SHIFT;
                        conv  <= 1'b0;          // conversion time over
                        cnt   <= '0;            // now counts sclk rises
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SHIFT: begin
                    sclk <= ~sclk;              // low one cycle, high one cycle
                    if (sclk_rise) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (last_bit) begin
                        state <= IDLE;          // sclk drops back low here too
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    conv  <= 1'b0;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    // shift in on each rise, data path only
    always_ff @(posedge clkadc) begin
        if (sclk_rise) begin
            for (int i = 1; i <= 4; i++) begin
                shreg[i] <= {shreg[i][SHIFT_BITS-2:0], miso[i]};  // MSB first
            end
        end
    end

    // held results, stable between frames
    always_ff @(posedge clkadc) begin
        if (rst) begin
            out1 <= '0;
            out2 <= '0;
            out3 <= '0;
            out4 <= '0;
        end else if (last_bit) begin
            out1 <= shreg[1];
            out2 <= shreg[2];
            out3 <= shreg[3];
            out4 <= shreg[4];
        end
    end

endmodule

`default_nettype wire

//--- hw/adc_cfg.sv
// Configuration block for the ADC readers.
// Holds the conversion enable and the sample period, written by a
// one-cycle reg_wen strobe into the config space. Periods below
// PERIOD_MIN are clamped. While enabled the timer issues start every
// period cycles; frame_done pulses are counted for readback.

`timescale 1ns/100ps
`default_nettype none

module adc_cfg (
    input  wire                clkadc,
    input  wire                rst,
    input  wire adc_pkg::reg_addr_t reg_waddr,
    input  wire adc_pkg::reg_data_t reg_wdata,
    input  wire                reg_wen,      // write strobe, one cycle
    input  wire                frame_done,   // from the current bank
    output logic               start,        // tick to both readers
    output logic               enable,
    output logic [15:0]        period,
    output adc_pkg::reg_data_t frame_count
);

    import adc_pkg::*;

    logic        cfg_wr;        // write hits config space
    logic        ctrl_wr;
    logic        period_wr;
    logic [15:0] period_new;    // clamped write value
    logic [15:0] tmr;           // cycles since last start

    assign cfg_wr    = reg_wen && reg_waddr[ADDR_CFG_BIT];
    assign ctrl_wr   = cfg_wr && (reg_waddr[CFG_OFS_W-1:0] == CFG_CTRL_ADDR);
    assign period_wr = cfg_wr && (reg_waddr[CFG_OFS_W-1:0] == CFG_PERIOD_ADDR);

    // clamp so a full frame always fits
    assign period_new = (reg_wdata[15:0] < 16'(PERIOD_MIN)) ? 16'(PERIOD_MIN)
                                                             : reg_wdata[15:0];

    // >= keeps the tick alive if period shrinks mid-count
    assign start = enable && (tmr >= period - 16'd1);

    // config registers
    always_ff @(posedge clkadc) begin
        if (rst) begin
            enable <= 1'b0;
            period <= 16'(PERIOD_MIN);
        end else begin
            if (ctrl_wr) begin
                enable <= reg_wdata[0];
            end
            if (period_wr) begin
                period <= period_new;
            end
        end
    end

    // period timer, held at zero while disabled
    always_ff @(posedge clkadc) begin
        if (rst || !enable || start) begin
            tmr <= '0;
        end else begin
            tmr <= tmr + 16'd1;
        end
    end

    // frame counter, wraps
    always_ff @(posedge clkadc) begin
        if (rst) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/adc_ctrl.sv
// ADC controller: pot bank and motor-current bank readers, the config
// block and the register read mux. A data read returns pot and current
// of one channel packed as {pot, cur}; a config read returns the control,
// period or frame counter register. Read data is combinational.

`timescale 1ns/100ps
`default_nettype none

module adc_ctrl (
    input  wire                      clkadc,
    input  wire                      rst,
    input  wire [1:8]                miso,        // 1-4 pot, 5-8 current
    input  wire adc_pkg::reg_addr_t  reg_raddr,
    output adc_pkg::reg_data_t       reg_rdata,
    input  wire adc_pkg::reg_addr_t  reg_waddr,
    input  wire adc_pkg::reg_data_t  reg_wdata,
    input  wire                      reg_wen,
    output wire [1:2]                sclk,        // 1 pot bank, 2 current bank
    output wire [1:2]                conv,
    output wire adc_pkg::adc_sample_t cur1,
    output wire adc_pkg::adc_sample_t cur2,
    output wire adc_pkg::adc_sample_t cur3,
    output wire adc_pkg::adc_sample_t cur4,
    output wire                      frame_done   // new samples valid
);

    import adc_pkg::*;

    adc_sample_t       potval [1:4];
    adc_sample_t       curval [1:4];
    logic              start;
    logic              enable;
    logic [15:0]       period;
    reg_data_t         frame_count;
    logic [CHAN_W-1:0] chan;

    adc_cfg adc_cfg_i (
        .clkadc      (clkadc),
        .rst         (rst),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .frame_done  (frame_done),
        .start       (start),
        .enable      (enable),
        .period      (period),
        .frame_count (frame_count)
    );

    // pot bank, its done is redundant with the current bank
    ltc1864_quad adc_pot (
        .clkadc (clkadc),
        .rst    (rst),
        .start  (start),
        .miso   (miso[1:4]),
        .sclk   (sclk[1]),
        .conv   (conv[1]),
        .out1   (potval[1]),
        .out2   (potval[2]),
        .out3   (potval[3]),
        .out4   (potval[4]),
        .done   ()
    );

    ltc1864_quad adc_cur (
        .clkadc (clkadc),
        .rst    (rst),
        .start  (start),
        .miso   (miso[5:8]),
        .sclk   (sclk[2]),
        .conv   (conv[2]),
        .out1   (curval[1]),
        .out2   (curval[2]),
        .out3   (curval[3]),
        .out4   (curval[4]),
        .done   (frame_done)    // both banks share timing
    );

    assign chan = reg_raddr[CHAN_LSB +: CHAN_W];

    // read mux
    always_comb begin
        reg_rdata = '0;
        if (!reg_raddr[ADDR_CFG_BIT]) begin
            if (chan >= 4'd1 && chan <= 4'd4) begin
                reg_rdata = {potval[chan], curval[chan]};  // pot in upper half
            end
        end else begin
            case (reg_raddr[CFG_OFS_W-1:0])
                CFG_CTRL_ADDR:   reg_rdata = {31'd0, enable};
                CFG_PERIOD_ADDR: reg_rdata = {16'd0, period};
                CFG_COUNT_ADDR:  reg_rdata = frame_count;
                default:         reg_rdata = '0;
            endcase
        end
    end

    // motor current straight out for the control loop
    assign cur1 = curval[1];
    assign cur2 = curval[2];
    assign cur3 = curval[3];
    assign cur4 = curval[4];

endmodule

`default_nettype wire

//--- hw/adc_top.sv
// Project top for the four-axis analog feedback subsystem.
// Brings the ADC controller out to pins: conv/sclk per bank, eight miso
// lines, the register read/write ports, the motor currents and the
// frame_done strobe.

`timescale 1ns/100ps
`default_nettype none

module adc_top (
    input  wire                       clkadc,
    input  wire                       rst,
    input  wire [1:8]                 miso,        // pot 1-4, current 5-8
    input  wire adc_pkg::reg_addr_t   reg_raddr,
    output wire adc_pkg::reg_data_t   reg_rdata,   // no read latency
    input  wire adc_pkg::reg_addr_t   reg_waddr,
    input  wire adc_pkg::reg_data_t   reg_wdata,
    input  wire                       reg_wen,     // one-cycle write strobe
    output wire [1:2]                 sclk,
    output wire [1:2]                 conv,
    output wire adc_pkg::adc_sample_t cur1,
    output wire adc_pkg::adc_sample_t cur2,
    output wire adc_pkg::adc_sample_t cur3,
    output wire adc_pkg::adc_sample_t cur4,
    output wire                       frame_done
);

    adc_ctrl adc_ctrl_i (
        .clkadc     (clkadc),
        .rst        (rst),
        .miso       (miso),
        .reg_raddr  (reg_raddr),
        .reg_rdata  (reg_rdata),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .sclk       (sclk),       // index 1 pot, 2 current
        .conv       (conv),
        .cur1       (cur1),
        .cur2       (cur2),
        .cur3       (cur3),
        .cur4       (cur4),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

//--- sim/ltc1864_model.sv
// Behavioral model of one LTC1864 ADC.
// The preset code is taken when conv rises. After conv falls the MSB is
// on miso, and each sclk fall moves to the next bit, so the reader can
// sample on sclk rise.

`timescale 1ns/100ps
`default_nettype none

module ltc1864_model (
    input  wire                       conv,
    input  wire                       sclk,
    input  wire adc_pkg::adc_sample_t code,   // value of the next conversion
    output wire                       miso
);

    import adc_pkg::*;

    adc_sample_t sample = '0;   // code held for this frame
    logic [3:0]  bitn = 4'd15;  // bit now on miso

    always @(posedge conv or negedge sclk) begin
        if (conv) begin
            sample <= code;                 // conversion starts here
            bitn   <= 4'd15;
        end else if (bitn != 4'd0) begin
            bitn <= bitn - 4'd1;            // next bit after each fall
        end
    end

    assign miso = conv ? 1'b0 : sample[bitn];   // quiet while converting

endmodule

`default_nettype wire

//--- sim/adc_assertions.sv
// Concurrent checks on the LTC1864 frame of one quad reader.
// Bound into every ltc1864_quad instance.

`timescale 1ns/100ps
`default_nettype none

module adc_assertions (
    input wire clkadc,
    input wire rst,
    input wire start,
    input wire sclk,
    input wire conv,
    input wire done
);

    // a frame begins only on a start tick
    conv_after_start: assert property (@(posedge clkadc) disable iff (rst)
        $rose(conv) |-> $past(start))
        else $error("conv rose without a start tick");

    // sclk stays low for the whole conversion
    no_sclk_in_conv: assert property (@(posedge clkadc) disable iff (rst)
        !(conv && sclk))
        else $error("sclk high while conv high");

    sclk_high_one: assert property (@(posedge clkadc) disable iff (rst)
        $rose(sclk) |=> $fell(sclk))
        else $error("sclk high for more than one cycle");

    // done is a one-cycle strobe, bus quiet when it comes
    done_strobe: assert property (@(posedge clkadc) disable iff (rst)
        done |=> !done)
        else $error("done wider than one cycle");

    done_bus_idle: assert property (@(posedge clkadc) disable iff (rst)
        done |-> (!conv && !sclk))
        else $error("done while conv or sclk active");

endmodule

bind ltc1864_quad adc_assertions adc_assertions_i (
    .clkadc (clkadc),
    .rst    (rst),
    .start  (start),
    .sclk   (sclk),
    .conv   (conv),
    .done   (done)
);

`default_nettype wire

//--- sim/adc_tb.sv
// Testbench for adc_top with eight LTC1864 models on the miso lines.
// Checks idle behavior, period clamp and readback, the packed channel
// words after each frame, frame spacing and count, and the held samples
// once conversion is switched off again.

`timescale 1ns/100ps
`default_nettype none

module adc_tb;

    import adc_pkg::*;

    localparam int PERIOD = 100;    // legal sample period for the frame test
    localparam int FRAMES = 5;

    logic        clkadc;
    logic        rst;
    reg_addr_t   reg_raddr;
    reg_addr_t   reg_waddr;
    reg_data_t   reg_wdata;
    logic        reg_wen;
    wire [1:8]   miso;
    wire [1:2]   sclk;
    wire [1:2]   conv;
    reg_data_t   reg_rdata;
    adc_sample_t cur1;
    adc_sample_t cur2;
    adc_sample_t cur3;
    adc_sample_t cur4;
    wire         frame_done;

    adc_sample_t code [1:8];        // what the models convert next
    adc_sample_t exp_code [1:8];    // codes of the last finished frame
    int          seed = 32'h9;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          frames_seen = 0;
    int          last_done = 0;     // cycle of the previous frame_done
    logic        timed_out = 1'b0;  // a frame never came
    reg_data_t   rd;

    initial begin
        clkadc = 1'b0;
        forever #50 clkadc = ~clkadc;
    end

    always @(posedge clkadc) cycle <= cycle + 1;

    adc_top adc_top_i (
        .clkadc     (clkadc),
        .rst        (rst),
        .miso       (miso),
        .reg_raddr  (reg_raddr),
        .reg_rdata  (reg_rdata),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .sclk       (sclk),
        .conv       (conv),
        .cur1       (cur1),
        .cur2       (cur2),
        .cur3       (cur3),
        .cur4       (cur4),
        .frame_done (frame_done)
    );

    // parts 1-4 on the pot bank and 5-8 on the current bank
    for (genvar g = 1; g <= 8; g++) begin : adc_chip
        ltc1864_model model_i (
            .conv (conv[(g - 1) / 4 + 1]),
            .sclk (sclk[(g - 1) / 4 + 1]),
            .code (code[g]),
            .miso (miso[g])
        );
    end

    // packed read word with pot in the upper half and 0 outside channels 1-4
    function automatic reg_data_t expected_word(input int ch);
        if (ch >= 1 && ch <= 4) begin
            return {exp_code[ch], exp_code[ch + 4]};
        end
        return '0;
    endfunction

    function automatic reg_addr_t data_addr(input int ch);
        reg_addr_t a;
        a = '0;
        a[CHAN_LSB +: CHAN_W] = ch[CHAN_W-1:0];
        return a;
    endfunction

    function automatic reg_addr_t cfg_addr(input logic [CFG_OFS_W-1:0] ofs);
        reg_addr_t a;
        a = '0;
        a[ADDR_CFG_BIT] = 1'b1;
        a[CFG_OFS_W-1:0] = ofs;
        return a;
    endfunction

    task automatic compare_word(input string what, input reg_data_t got,
                                input reg_data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, want);
        end
    endtask

    // read data is combinational so it is sampled mid cycle
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge clkadc);
        reg_raddr <= addr;
        @(negedge clkadc);
        data = reg_rdata;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clkadc);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge clkadc);
        reg_wen   <= 1'b0;          // one-cycle strobe
    endtask

    task automatic check_channels();
        reg_data_t r;
        for (int ch = 0; ch < 16; ch++) begin
            read_reg(data_addr(ch), r);
            compare_word($sformatf("channel %0d", ch), r, expected_word(ch));
        end
    endtask

    task automatic new_codes();
        @(posedge clkadc);
        for (int i = 1; i <= 8; i++) begin
            code[i] <= 16'($random(seed));
        end
    endtask

    task automatic wait_frame(input int limit);
        int waited;
        waited = 0;
        @(negedge clkadc);
        while (!frame_done && waited < limit) begin
            @(negedge clkadc);
            waited++;
        end
        if (!frame_done) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout, no frame_done within %0d cycles", limit);
        end
    endtask

    // frame count and spacing watched on every cycle
    always @(negedge clkadc) begin
        if (!rst && frame_done) begin
            checks++;
            if (frames_seen > 0 && cycle - last_done != PERIOD) begin
                errors++;
                $display("** Error at %0t: frame_done spacing %0d cycles, expected %0d",
                         $time, cycle - last_done, PERIOD);
            end
            last_done = cycle;
            frames_seen++;
        end
    end

    initial begin
        rst       = 1'b1;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        for (int i = 1; i <= 8; i++) begin
            code[i]     = 16'($random(seed));
            exp_code[i] = '0;       // samples clear after reset
        end
        repeat (8) @(posedge clkadc);
        rst <= 1'b0;

        // nothing may run while enable is 0
        for (int n = 0; n < 200; n++) begin
            @(negedge clkadc);
            if (frame_done || conv != 2'b00 || sclk != 2'b00) begin
                errors++;
                $display("** Error at %0t: frame activity with conversion disabled", $time);
            end
        end
        check_channels();
        read_reg(cfg_addr(CFG_CTRL_ADDR), rd);
        compare_word("control after reset", rd, 32'd0);
        read_reg(cfg_addr(CFG_PERIOD_ADDR), rd);
        compare_word("period after reset", rd, reg_data_t'(PERIOD_MIN));

        // short period is clamped and a legal one kept
        write_reg(cfg_addr(CFG_PERIOD_ADDR), 32'd10);
        read_reg(cfg_addr(CFG_PERIOD_ADDR), rd);
        compare_word("clamped period", rd, reg_data_t'(PERIOD_MIN));
        write_reg(cfg_addr(CFG_PERIOD_ADDR), reg_data_t'(PERIOD));
        read_reg(cfg_addr(CFG_PERIOD_ADDR), rd);
        compare_word("period", rd, reg_data_t'(PERIOD));
        write_reg(cfg_addr(CFG_CTRL_ADDR), 32'd1);
        read_reg(cfg_addr(CFG_CTRL_ADDR), rd);
        compare_word("control", rd, 32'd1);

        for (int f = 0; f < FRAMES; f++) begin
            wait_frame(2 * PERIOD);
            if (timed_out) begin
                break;
            end
            for (int i = 1; i <= 8; i++) begin
                exp_code[i] = code[i];      // what this frame converted
            end
            new_codes();                    // ready well before next conv
            if (f == FRAMES - 1) begin
                write_reg(cfg_addr(CFG_CTRL_ADDR), 32'd0);  // before next start
            end
            check_channels();
            compare_word("cur1", reg_data_t'(cur1), reg_data_t'(exp_code[5]));
            compare_word("cur2", reg_data_t'(cur2), reg_data_t'(exp_code[6]));
            compare_word("cur3", reg_data_t'(cur3), reg_data_t'(exp_code[7]));
            compare_word("cur4", reg_data_t'(cur4), reg_data_t'(exp_code[8]));
            read_reg(cfg_addr(CFG_COUNT_ADDR), rd);
            compare_word("frame count", rd, reg_data_t'(frames_seen));
        end

        // last samples must hold once conversion is off
        if (!timed_out) begin
            for (int n = 0; n < 2 * PERIOD; n++) begin
                @(negedge clkadc);
                if (frame_done) begin
                    errors++;
                    $display("** Error at %0t: frame_done after conversion was disabled",
                             $time);
                end
            end
            check_channels();
            read_reg(cfg_addr(CFG_CTRL_ADDR), rd);
            compare_word("control after disable", rd, 32'd0);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/adc_pkg.sv
hw/ltc1864_quad/ltc1864_quad.sv
hw/adc_cfg.sv
hw/adc_ctrl.sv
hw/adc_top.sv
sim/ltc1864_model.sv
sim/adc_assertions.sv
sim/adc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the ADC testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module adc_tb -o adc_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/adc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -x -F '>>> PASS'; then
    exit 0
fi
exit 1
